// File: modsq_engine.f
verilog/modsq_pkg.sv
verilog/square_columns.sv
verilog/residue_reduce.sv
verilog/final_correct.sv
verilog/modsq_engine.sv
testbench/modsq_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module modsq_engine_tb \
    -f modsq_engine.f \
    -o modsq_sim

sim_output=$(./obj_dir/modsq_sim)
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi

// File: testbench/modsq_engine_tb.sv
`timescale 1ns/100ps
`default_nettype none

module modsq_engine_tb;

    localparam int COUNT_WIDTH = 16;
    localparam int MAX_COUNT   = 20;
    localparam int NUM_JOBS    = 30;
    localparam int WATCHDOG_CYCLES = NUM_JOBS * (2 * MAX_COUNT + 100);

    // P = 2^64 - 59.
    localparam logic [63:0] P = 64'hFFFF_FFFF_FFFF_FFC5;

    logic                   clk;
    logic                   reset;
    logic                   start;
    logic [63:0]            x_in;
    logic [COUNT_WIDTH-1:0] count;
    logic                   busy;
    logic                   done;
    logic [63:0]            result;

    int          error_count;
    int          tests_run;
    int          tests_failed;
    string       current_test;

    modsq_engine #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) uut (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .x_in   (x_in),
        .count  (count),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("TIMEOUT: test %s hung, no done within %0d cycles", current_test,
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // Repeated squaring mod P with full 128-bit products.
    function automatic logic [63:0] square_mod_p(input logic [63:0] x, input int n);
        logic [127:0] acc;
        acc = {64'b0, x};
        for (int i = 0; i < n; i++) begin
            acc = (acc * acc) % {64'b0, P};
        end
        return acc[63:0];
    endfunction

    function automatic logic [63:0] random_below_p();
        logic [63:0] x;
        x = {$urandom, $urandom};
        if (x >= P) begin
            x = x - P;
        end
        return x;
    endfunction

    function automatic int random_count();
        return int'($urandom % MAX_COUNT) + 1;
    endfunction

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("PASS  %s", name);
        end
        else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
    endtask

    // Runs one job from a falling edge; optionally fires a second start while busy.
    task automatic run_job(input string name, input logic [63:0] x, input int n,
                           input bit interfere);
        logic [63:0] expected;
        int          errs_before;
        int          cyc;
        expected     = square_mod_p(x, n);
        errs_before  = error_count;
        current_test = name;
        start = 1'b1;
        x_in  = x;
        count = COUNT_WIDTH'(n);
        @(negedge clk);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("ERROR: %s busy did not rise after start", name);
            error_count++;
        end
        cyc = 0;
        while (done !== 1'b1) begin
            if (interfere && cyc == 2) begin
                start = 1'b1;
                x_in  = x ^ 64'h5A5A_A5A5_0F0F_F0F0;
                count = COUNT_WIDTH'(n + 3);
            end
            else begin
                start = 1'b0;
            end
            @(negedge clk);
            cyc++;
        end
        start = 1'b0;
        if (busy !== 1'b0) begin
            $display("ERROR: %s busy still high in the done cycle", name);
            error_count++;
        end
        if (result !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, result);
            error_count++;
        end
        // Result must hold and no second job may appear.
        repeat (10) begin
            @(negedge clk);
            if (done !== 1'b0) begin
                $display("ERROR: %s extra done pulse after the job ended", name);
                error_count++;
            end
            if (busy !== 1'b0) begin
                $display("ERROR: %s engine became busy without a start", name);
                error_count++;
            end
            if (result !== expected) begin
                $display("MISMATCH %s (hold): expected %h, actual %h", name, expected, result);
                error_count++;
            end
        end
        finish_test(name, errs_before);
    endtask

    initial begin
        int errs_before;
        reset        = 1'b1;
        start        = 1'b0;
        x_in         = '0;
        count        = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        current_test = "reset";
        void'($urandom(32'h2343));

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        current_test = "reset_idle";
        errs_before  = error_count;
        repeat (10) begin
            @(negedge clk);
            if (busy !== 1'b0 || done !== 1'b0) begin
                $display("ERROR: reset_idle busy or done high with no start");
                error_count++;
            end
        end
        finish_test("reset_idle", errs_before);

        for (int i = 0; i < 5; i++) begin
            run_job($sformatf("count_zero_%0d", i), random_below_p(), 0, 1'b0);
        end

        for (int i = 0; i < 20; i++) begin
            run_job($sformatf("random_%0d", i), random_below_p(), random_count(), 1'b0);
        end

        run_job("edge_zero", 64'd0, random_count(), 1'b0);
        run_job("edge_one", 64'd1, random_count(), 1'b0);
        run_job("edge_p_minus_1", P - 64'd1, random_count(), 1'b0);
        run_job("edge_2_pow_63", 64'h8000_0000_0000_0000, random_count(), 1'b0);

        run_job("start_while_busy", random_below_p(), 8, 1'b1);

        $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end
        else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/modsq_engine.sv
`timescale 1ns/100ps
`default_nettype none

module modsq_engine #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [modsq_pkg::MOD_WIDTH-1:0] x_in,
    input  logic [COUNT_WIDTH-1:0]          count,
    output logic                            busy,
    output logic                            done,
    output logic [modsq_pkg::MOD_WIDTH-1:0] result
);

    import modsq_pkg::*;

    localparam logic [5:0] IDLE   = 6'b000001;
    localparam logic [5:0] LOAD   = 6'b000010;
    localparam logic [5:0] SQUARE = 6'b000100;
    localparam logic [5:0] REDUCE = 6'b001000;
    localparam logic [5:0] FINISH = 6'b010000;
    localparam logic [5:0] REPORT = 6'b100000;

    logic [5:0]             state;
    logic [COUNT_WIDTH-1:0] counter;
    logic                   accept;
    logic                   go;
    logic                   ready;

    operand_u  load_word;
    operand_u  corrected;
    limb_vec_t load_limbs;
    limb_vec_t operand_reg;
    limb_vec_t reduced;
    product_t  columns;
    product_t  product_reg;

    // Busy is low in both of these states.
    assign accept = start && (state == IDLE || state == REPORT);

    // Zero-extend x_in into digits, redundant bits clear.
    always_comb begin
        load_word.flat = {{(NUM_LIMBS*WORD_LEN-MOD_WIDTH){1'b0}}, x_in};
        for (int i = 0; i < NUM_LIMBS; i++) begin
            load_limbs[i] = {{(BIT_LEN-WORD_LEN){1'b0}}, load_word.limbs[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            counter <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
            go      <= 1'b0;
        end
        else begin
            done <= 1'b0;
            go   <= 1'b0;
            case (state)
                IDLE, REPORT: begin
                    if (accept) begin
                        state   <= LOAD;
                        counter <= count;
                        busy    <= 1'b1;
                    end
                    else begin
                        state <= IDLE;
                    end
                end
                LOAD: begin
                    if (counter == '0) begin
                        state <= FINISH;
                        go    <= 1'b1;
                    end
                    else begin
                        state <= SQUARE;
                    end
                end
                SQUARE: state <= REDUCE;
                REDUCE: begin
                    counter <= counter - 1'b1;
                    if (counter == COUNT_WIDTH'(1)) begin
                        state <= FINISH;
                        go    <= 1'b1;
                    end
                    else begin
                        state <= SQUARE;
                    end
                end
                FINISH: begin
                    if (ready) begin
                        state <= REPORT;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            operand_reg <= load_limbs;
        end
        else if (state == REDUCE) begin
            operand_reg <= reduced;
        end
        if (state == SQUARE) begin
            product_reg <= columns;
        end
        if (state == FINISH && ready) begin
            result <= corrected.flat[MOD_WIDTH-1:0];
        end
    end

    square_columns u_square_columns (
        .operand (operand_reg),
        .columns (columns)
    );

    residue_reduce u_residue_reduce (
        .columns (product_reg),
        .reduced (reduced)
    );

    final_correct u_final_correct (
        .clk       (clk),
        .reset     (reset),
        .go        (go),
        .operand   (operand_reg),
        .ready     (ready),
        .corrected (corrected)
    );

endmodule

`default_nettype wire

// File: verilog/final_correct.sv
`timescale 1ns/100ps
`default_nettype none

module final_correct (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 go,
    input  modsq_pkg::limb_vec_t operand,
    output logic                 ready,
    output modsq_pkg::operand_u  corrected
);

    import modsq_pkg::*;

    localparam int FLAT_LEN = NUM_LIMBS * WORD_LEN;

    logic                active;
    logic [FLAT_LEN-1:0] normalized;
    logic [FLAT_LEN:0]   diff;

    // Carry propagation of the redundant limbs.
    always_comb begin
        normalized = '0;
        for (int i = 0; i < NUM_LIMBS; i++) begin
            normalized = normalized + (FLAT_LEN'(operand[i]) << (i * WORD_LEN));
        end
    end

    // Top bit is the borrow.
    assign diff = {1'b0, corrected.flat} - {{(FLAT_LEN+1-MOD_WIDTH){1'b0}}, MODULUS};

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            ready  <= 1'b0;
        end
        else begin
            ready <= 1'b0;
            if (go) begin
                active <= 1'b1;
            end
            else if (active && diff[FLAT_LEN]) begin
                active <= 1'b0;
                ready  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            corrected.flat <= normalized;
        end
        else if (active && !diff[FLAT_LEN]) begin
            corrected.flat <= diff[FLAT_LEN-1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/residue_reduce.sv
`timescale 1ns/100ps
`default_nettype none

module residue_reduce (
    input  modsq_pkg::product_t  columns,
    output modsq_pkg::limb_vec_t reduced
);

    import modsq_pkg::*;

    // Columns below bit 64 are kept as they are.
    localparam int LOW_COLS   = MOD_WIDTH / WORD_LEN;
    localparam int NUM_HIGH   = NUM_COLS - LOW_COLS;
    localparam int NUM_CHUNKS = (COL_LEN + CHUNK_LEN - 1) / CHUNK_LEN;
    localparam int PAD_LEN    = NUM_CHUNKS * CHUNK_LEN;
    localparam int NUM_RES    = NUM_HIGH * NUM_CHUNKS;
    localparam int LUT_SIZE   = 2 ** CHUNK_LEN;
    // One low column plus one digit from every residue.
    localparam int SUM_LEN    = WORD_LEN + $clog2(NUM_RES + 2);

    function automatic logic [LUT_SIZE-1:0][MOD_WIDTH-1:0] build_lut(input int pos);
        logic [LUT_SIZE-1:0][MOD_WIDTH-1:0] lut;
        for (int e = 0; e < LUT_SIZE; e++) begin
            lut[e] = residue_of(CHUNK_LEN'(e), pos);
        end
        return lut;
    endfunction

    logic [NUM_RES-1:0][MOD_WIDTH-1:0] residue;
    logic [LOW_COLS-1:0][SUM_LEN-1:0]  limb_sum;

    for (genvar h = 0; h < NUM_HIGH; h++) begin : g_high
        logic [PAD_LEN-1:0] padded;

        assign padded = {{(PAD_LEN-COL_LEN){1'b0}}, columns[LOW_COLS+h]};

        for (genvar c = 0; c < NUM_CHUNKS; c++) begin : g_chunk
            // Table for the chunk at bit (LOW_COLS + h) * 16 + c * 6.
            localparam logic [LUT_SIZE-1:0][MOD_WIDTH-1:0] LUT =
                build_lut((LOW_COLS + h) * WORD_LEN + c * CHUNK_LEN);

            assign residue[h*NUM_CHUNKS+c] = LUT[padded[c*CHUNK_LEN +: CHUNK_LEN]];
        end
    end

    // Add residue digits onto the low columns, limb by limb.
    always_comb begin
        for (int i = 0; i < LOW_COLS; i++) begin
            limb_sum[i] = SUM_LEN'(columns[i]);
            for (int r = 0; r < NUM_RES; r++) begin
                limb_sum[i] = limb_sum[i] + SUM_LEN'(residue[r][i*WORD_LEN +: WORD_LEN]);
            end
        end
    end

    // Single carry fold; the last carry lands in the headroom limb.
    always_comb begin
        reduced[0] = BIT_LEN'(limb_sum[0][WORD_LEN-1:0]);
        for (int i = 1; i < LOW_COLS; i++) begin
            reduced[i] = BIT_LEN'(limb_sum[i][WORD_LEN-1:0])
                       + BIT_LEN'(limb_sum[i-1][SUM_LEN-1:WORD_LEN]);
        end
        reduced[LOW_COLS] = BIT_LEN'(limb_sum[LOW_COLS-1][SUM_LEN-1:WORD_LEN]);
    end

endmodule

`default_nettype wire

// File: verilog/square_columns.sv
`timescale 1ns/100ps
`default_nettype none

module square_columns (
    input  modsq_pkg::limb_vec_t operand,
    output modsq_pkg::product_t  columns
);

    import modsq_pkg::*;

    localparam int PP_LEN   = 2 * BIT_LEN;
    // At most NUM_LIMBS partial products land in one column.
    localparam int SUM_LEN  = PP_LEN + $clog2(NUM_LIMBS);
    localparam int FOLD_LEN = SUM_LEN - WORD_LEN + 1;

    logic [NUM_COLS-1:0][SUM_LEN-1:0]  col_sum;
    logic [NUM_COLS-1:0][FOLD_LEN-1:0] fold_once;

    // Upper triangle only; off-diagonal products stand for both halves of the grid.
    always_comb begin
        logic [PP_LEN-1:0] pp;
        col_sum = '0;
        for (int i = 0; i < NUM_LIMBS; i++) begin
            for (int j = i; j < NUM_LIMBS; j++) begin
                pp = PP_LEN'(operand[i]) * PP_LEN'(operand[j]);
                if (i == j) begin
                    col_sum[i+j] = col_sum[i+j] + SUM_LEN'(pp);
                end
                else begin
                    col_sum[i+j] = col_sum[i+j] + (SUM_LEN'(pp) << 1);
                end
            end
        end
    end

    // First fold.
    always_comb begin
        fold_once[0] = FOLD_LEN'(col_sum[0][WORD_LEN-1:0]);
        for (int k = 1; k < NUM_COLS; k++) begin
            fold_once[k] = FOLD_LEN'(col_sum[k][WORD_LEN-1:0])
                         + FOLD_LEN'(col_sum[k-1][SUM_LEN-1:WORD_LEN]);
        end
    end

    // Second fold leaves every column within COL_LEN bits.
    // The square stays below 2^160, so the top column never carries out.
    always_comb begin
        columns[0] = COL_LEN'(fold_once[0][WORD_LEN-1:0]);
        for (int k = 1; k < NUM_COLS; k++) begin
            columns[k] = COL_LEN'(fold_once[k][WORD_LEN-1:0])
                       + COL_LEN'(fold_once[k-1][FOLD_LEN-1:WORD_LEN]);
        end
    end

endmodule

`default_nettype wire

// File: verilog/modsq_pkg.sv
`default_nettype none

package modsq_pkg;

    localparam int WORD_LEN  = 16;
    localparam int BIT_LEN   = 17;

    // Four digits hold the value, the fifth is headroom.
    localparam int NUM_LIMBS = 5;

    localparam int MOD_WIDTH = 64;

    // P = 2^64 - 59.
    localparam logic [MOD_WIDTH-1:0] MODULUS = 64'hFFFF_FFFF_FFFF_FFC5;

    localparam int NUM_COLS  = 2 * NUM_LIMBS;
    localparam int COL_LEN   = BIT_LEN;
    localparam int CHUNK_LEN = 6;

    typedef logic [NUM_LIMBS-1:0][BIT_LEN-1:0] limb_vec_t;

    typedef logic [NUM_COLS-1:0][COL_LEN-1:0] product_t;

    // Normal operand, seen as digits or as one integer.
    typedef union packed {
        logic [NUM_LIMBS-1:0][WORD_LEN-1:0] limbs;
        logic [NUM_LIMBS*WORD_LEN-1:0]      flat;
    } operand_u;

    // Chunk times 2^pos, reduced mod P one doubling at a time.
    function automatic logic [MOD_WIDTH-1:0] residue_of(input logic [CHUNK_LEN-1:0] chunk,
                                                        input int pos);
        logic [MOD_WIDTH:0] acc;
        acc = {{(MOD_WIDTH+1-CHUNK_LEN){1'b0}}, chunk};
        for (int i = 0; i < pos; i++) begin
            acc = acc << 1;
            if (acc >= {1'b0, MODULUS}) begin
                acc = acc - {1'b0, MODULUS};
            end
        end
        return acc[MOD_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire
